// File: project.f
cpu_isa_pkg.sv
cpu_pipe_pkg.sv
cpu_regfile.sv
cpu_decode.sv
cpu_execute.sv
cpu_result.sv
cpu_top.sv
tb_cpu_top.sv

// File: tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
();

    localparam int DIRECTED_INSTRS = 36;
    localparam int RANDOM_INSTRS   = 200;
    localparam int CYCLE_LIMIT     = 4 * (DIRECTED_INSTRS + RANDOM_INSTRS) + 200;

    logic    clk;
    logic    rst;
    logic    instr_valid;
    instr_u  instr;
    logic    instr_ready;
    logic    retire_valid;
    retire_t retire;
    logic    retire_ready;

    // Reference state and expected records in program order
    word_t   m_regs [NUM_REGS];
    word_t   m_mem  [DMEM_WORDS];
    retire_t exp_q  [$];

    int      value_errors    = 0;
    int      protocol_errors = 0;
    int      retired         = 0;
    int      cycles          = 0;
    logic    rand_gaps       = 1'b0;
    logic    rand_ready      = 1'b0;

    cpu_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_ready  (instr_ready),
        .retire_valid (retire_valid),
        .retire       (retire),
        .retire_ready (retire_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // Instruction encoding and model
    ////////////////////////////////////////

    function automatic instr_u r_format(opcode_t op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
        instr_u w;
        w.r = '{opcode: op, rd: rd, rs: rs, rt: rt, unused: 3'b000};
        return w;
    endfunction

    function automatic instr_u i_format(opcode_t op, reg_idx_t rd, reg_idx_t rs,
                                        logic [IMM_W-1:0] imm);
        instr_u w;
        w.i = '{opcode: op, rd: rd, rs: rs, imm: imm};
        return w;
    endfunction

    function automatic word_t sign_extend(logic [IMM_W-1:0] imm);
        return {{(16 - IMM_W){imm[IMM_W-1]}}, imm};
    endfunction

    // Executes one accepted instruction and queues its record
    task automatic model_step(input instr_u w);
        retire_t rec;
        word_t   a;
        word_t   b;
        word_t   res;
        word_t   addr;
        a    = m_regs[w.r.rs];
        b    = m_regs[w.r.rt];
        addr = a + sign_extend(w.i.imm);
        case (w.r.opcode)
            ADD:     res = a + b;
            SUB:     res = a - b;
            AND:     res = a & b;
            OR:      res = a | b;
            XOR:     res = a ^ b;
            SLL:     res = a << b[3:0];
            ADDI:    res = addr;
            LI:      res = {{(16 - IMM_W){1'b0}}, w.i.imm};
            LW:      res = m_mem[addr[DMEM_AW-1:0]];
            SW:      res = m_regs[w.i.rd];
            default: res = '0;
        endcase
        if (w.r.opcode == SW)
            m_mem[addr[DMEM_AW-1:0]] = res;
        else if (w.r.opcode != NOP && w.r.rd != 3'd0)
            m_regs[w.r.rd] = res;
        rec.opcode = w.r.opcode;
        rec.rd     = w.r.rd;
        rec.value  = res;
        rec.addr   = (w.r.opcode == LW || w.r.opcode == SW) ? addr : '0;
        exp_q.push_back(rec);
    endtask

    // Record fields for error lines
    function automatic string record_text(input retire_t r);
        return $sformatf("op=%0d rd=%0d value=%h addr=%h",
                         r.opcode, r.rd, r.value, r.addr);
    endfunction

    task automatic check_retire(input retire_t exp, input retire_t act, input string what);
        if (act !== exp)
        begin
            value_errors++;
            $display("FAIL %0t %s: expected %s, got %s",
                     $time, what, record_text(exp), record_text(act));
        end
    endtask

    ////////////////////////////////////////
    // Stream drivers
    ////////////////////////////////////////

    // Offers one instruction until the core takes it
    task automatic send_instr(input instr_u w);
        logic done;
        done = 1'b0;
        while (!done)
        begin
            @(negedge clk);
            if (rand_gaps && ($urandom_range(3) == 0))
            begin
                instr_valid = 1'b0;
            end
            else
            begin
                instr_valid = 1'b1;
                instr       = w;
                #1;
                if (instr_ready)
                begin
                    model_step(w);
                    done = 1'b1;
                end
            end
        end
    endtask

    task automatic drain;
        @(negedge clk);
        instr_valid = 1'b0;
        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (3) @(negedge clk);
    endtask

    // Retire side consumer and stability watch
    initial
    begin
        retire_t held_rec;
        logic    was_held;
        was_held = 1'b0;
        forever
        begin
            @(negedge clk);
            retire_ready = rand_ready ? ($urandom_range(3) != 0) : 1'b1;
            #1;
            if (!rst)
            begin
                if (was_held)
                begin
                    if (!retire_valid)
                    begin
                        protocol_errors++;
                        $display("Retire record dropped at %0t while retire_ready was low", $time);
                    end
                    else
                        check_retire(held_rec, retire, "held record");
                end
                was_held = retire_valid && !retire_ready;
                held_rec = retire;
                if (retire_valid && retire_ready)
                begin
                    retired++;
                    if (exp_q.size() == 0)
                    begin
                        protocol_errors++;
                        $display("Unexpected retire record at %0t with nothing outstanding", $time);
                    end
                    else
                        check_retire(exp_q.pop_front(), retire, "retire");
                end
            end
        end
    end

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic reset_defaults;
        @(negedge clk);
        #1;
        if (retire_valid !== 1'b0)
        begin
            value_errors++;
            $display("FAIL %0t: retire_valid is %b after reset, expected 0", $time, retire_valid);
        end
        if (instr_ready !== 1'b1)
        begin
            value_errors++;
            $display("FAIL %0t: instr_ready is %b after reset, expected 1", $time, instr_ready);
        end
        for (int i = 0; i < NUM_REGS; i++)
            send_instr(r_format(ADD, reg_idx_t'(i), reg_idx_t'(i), reg_idx_t'(i)));
        drain();
    endtask

    // Each op depends on the one or two before it
    task automatic alu_chain;
        send_instr(i_format(LI,   3'd1, 3'd0, 6'd21));
        send_instr(i_format(ADDI, 3'd2, 3'd1, 6'h3d));
        send_instr(r_format(ADD,  3'd3, 3'd1, 3'd2));
        send_instr(r_format(SUB,  3'd4, 3'd3, 3'd1));
        send_instr(r_format(AND,  3'd5, 3'd4, 3'd3));
        send_instr(r_format(OR,   3'd6, 3'd5, 3'd2));
        send_instr(r_format(XOR,  3'd7, 3'd6, 3'd3));
        send_instr(r_format(SLL,  3'd1, 3'd7, 3'd2));
        send_instr(r_format(ADD,  3'd2, 3'd1, 3'd1));
        send_instr(r_format(SUB,  3'd3, 3'd2, 3'd7));
        drain();
    endtask

    task automatic load_store_mix;
        send_instr(i_format(LI,   3'd1, 3'd0, 6'h2a));
        send_instr(i_format(LI,   3'd2, 3'd0, 6'd3));
        send_instr(i_format(SW,   3'd1, 3'd2, 6'd4));
        send_instr(i_format(SW,   3'd2, 3'd2, 6'h3f));
        send_instr(i_format(LW,   3'd3, 3'd2, 6'd4));
        // Load-use on both sources
        send_instr(r_format(ADD,  3'd4, 3'd3, 3'd3));
        send_instr(i_format(LW,   3'd5, 3'd2, 6'h3f));
        send_instr(r_format(SUB,  3'd6, 3'd5, 3'd3));
        send_instr(i_format(LW,   3'd7, 3'd0, 6'd1));
        send_instr(i_format(SW,   3'd4, 3'd2, 6'd12));
        send_instr(i_format(LW,   3'd1, 3'd0, 6'd15));
        send_instr(i_format(ADDI, 3'd1, 3'd1, 6'd1));
        drain();
    endtask

    task automatic r0_write_guard;
        send_instr(i_format(LI,   3'd0, 3'd0, 6'd17));
        send_instr(r_format(ADD,  3'd0, 3'd1, 3'd2));
        send_instr(r_format(ADD,  3'd3, 3'd0, 3'd0));
        send_instr(i_format(ADDI, 3'd4, 3'd0, 6'd5));
        send_instr(i_format(LW,   3'd0, 3'd0, 6'd7));
        send_instr(r_format(ADD,  3'd5, 3'd0, 3'd4));
        drain();
    endtask

    // Random ops with input gaps and retire back-pressure
    task automatic random_stream;
        opcode_t op;
        instr_u  w;
        rand_gaps  = 1'b1;
        rand_ready = 1'b1;
        for (int n = 0; n < RANDOM_INSTRS; n++)
        begin
            op = opcode_t'($urandom_range(10, 1));
            if (op inside {ADD, SUB, AND, OR, XOR, SLL})
                w = r_format(op, reg_idx_t'($urandom_range(7)), reg_idx_t'($urandom_range(7)),
                             reg_idx_t'($urandom_range(7)));
            else
                w = i_format(op, reg_idx_t'($urandom_range(7)), reg_idx_t'($urandom_range(7)),
                             6'($urandom_range(63)));
            send_instr(w);
        end
        drain();
        rand_gaps  = 1'b0;
        rand_ready = 1'b0;
    endtask

    ////////////////////////////////////////
    // Run control
    ////////////////////////////////////////

    initial
    begin
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d records still expected", cycles, exp_q.size());
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        void'($urandom(56615));
        rst          = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        retire_ready = 1'b0;
        for (int i = 0; i < NUM_REGS; i++)
            m_regs[i] = '0;
        for (int i = 0; i < DMEM_WORDS; i++)
            m_mem[i] = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_defaults();
        alu_chain();
        load_store_mix();
        r0_write_guard();
        random_stream();

        $display("Errors: value %0d, protocol %0d, records retired %0d",
                 value_errors, protocol_errors, retired);
        if (value_errors == 0 && protocol_errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: cpu_top.sv
`timescale 1ns/1ps

module cpu_top
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    instr_valid,
    input  instr_u  instr,
    output logic    instr_ready,
    output logic    retire_valid,
    output retire_t retire,
    input  logic    retire_ready
);

    ////////////////////////////////////////
    // Stage links
    ////////////////////////////////////////

    exe_op_t  x_op;
    res_op_t  r_op;
    logic     hold;
    logic     stall_ld;

    // Register write-back
    logic     w_en;
    reg_idx_t w_idx;
    word_t    w_data;

    cpu_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .hold        (hold),
        .stall_ld    (stall_ld),
        .w_en        (w_en),
        .w_idx       (w_idx),
        .w_data      (w_data),
        .x_op        (x_op)
    );

    cpu_execute u_execute (
        .clk      (clk),
        .rst      (rst),
        .x_op     (x_op),
        .hold     (hold),
        .w_en     (w_en),
        .w_idx    (w_idx),
        .w_data   (w_data),
        .stall_ld (stall_ld),
        .r_op     (r_op)
    );

    cpu_result u_result (
        .clk          (clk),
        .rst          (rst),
        .r_op         (r_op),
        .hold         (hold),
        .w_en         (w_en),
        .w_idx        (w_idx),
        .w_data       (w_data),
        .retire_valid (retire_valid),
        .retire       (retire),
        .retire_ready (retire_ready)
    );

endmodule

// File: cpu_result.sv
`timescale 1ns/1ps

module cpu_result
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  res_op_t  r_op,
    output logic     hold,
    output logic     w_en,
    output reg_idx_t w_idx,
    output word_t    w_data,
    output logic     retire_valid,
    output retire_t  retire,
    input  logic     retire_ready
);

    word_t              dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0] mem_addr;
    word_t              ld_data;
    logic               do_store;
    retire_t            ret_next;

    // Full retire slot not taken stalls the whole core
    assign hold = retire_valid && !retire_ready;

    assign mem_addr = r_op.value[DMEM_AW-1:0];
    assign ld_data  = dmem[mem_addr];
    assign do_store = r_op.valid && (r_op.opcode == SW) && !hold;

    ////////////////////////////////////////
    // Write-back port
    ////////////////////////////////////////

    // Fires on the edge the op moves into retire
    assign w_en   = r_op.valid && r_op.wr && !hold;
    assign w_idx  = r_op.rd;
    assign w_data = (r_op.opcode == LW) ? ld_data : r_op.value;

    ////////////////////////////////////////
    // Data memory
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < DMEM_WORDS; i++)
            begin
                dmem[i] <= '0;
            end
        end
        else if (do_store)
        begin
            dmem[mem_addr] <= r_op.sdata;
        end
    end

    ////////////////////////////////////////
    // Retire register
    ////////////////////////////////////////

    always_comb
    begin
        ret_next.opcode = r_op.opcode;
        ret_next.rd     = r_op.rd;
        ret_next.value  = w_data;
        ret_next.addr   = '0;
        if (r_op.opcode == SW)
            ret_next.value = r_op.sdata;
        if ((r_op.opcode == LW) || (r_op.opcode == SW))
            ret_next.addr = r_op.value;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            retire_valid <= 1'b0;
        else if (!hold)
            retire_valid <= r_op.valid;
    end

    always_ff @(posedge clk)
    begin
        if (!hold && r_op.valid)
            retire <= ret_next;
    end

    // Record waits unchanged for the consumer
    a_retire_stable : assert property (@(posedge clk) disable iff (rst)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire));

endmodule

// File: cpu_execute.sv
`timescale 1ns/1ps

module cpu_execute
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  exe_op_t  x_op,
    input  logic     hold,
    input  logic     w_en,
    input  reg_idx_t w_idx,
    input  word_t    w_data,
    output logic     stall_ld,
    output res_op_t  r_op
);

    typedef struct packed {
        logic     en;
        reg_idx_t idx;
        word_t    data;
    } wb_ent_t;

    // Register writes done at the last edge and the one before
    wb_ent_t wb_last;
    wb_ent_t wb_prev;
    word_t   op_a;
    word_t   op_b;
    word_t   alu_out;
    res_op_t r_next;

    ////////////////////////////////////////
    // Operand forwarding
    ////////////////////////////////////////

    // Newest producer wins and r0 never forwards
    function automatic word_t fwd_operand(
        input reg_idx_t src,
        input word_t    dec
    );
        word_t val;
        val = dec;
        if (src != '0)
        begin
            if (r_op.valid && r_op.wr && (r_op.rd == src))
                val = r_op.value;
            else if (wb_last.en && (wb_last.idx == src))
                val = wb_last.data;
            else if (wb_prev.en && (wb_prev.idx == src))
                val = wb_prev.data;
        end
        return val;
    endfunction

    always_comb
    begin
        op_a = fwd_operand(x_op.rs, x_op.a);
        op_b = fwd_operand(x_op.rt, x_op.b);
    end

    // Load data is not ready until the load leaves r_op
    assign stall_ld = x_op.valid && r_op.valid && (r_op.opcode == LW) && (r_op.rd != '0)
                      && ((x_op.rs == r_op.rd) || (x_op.rt == r_op.rd));

    ////////////////////////////////////////
    // ALU and address
    ////////////////////////////////////////

    always_comb
    begin
        case (x_op.opcode)
            ADD:          alu_out = op_a + op_b;
            SUB:          alu_out = op_a - op_b;
            AND:          alu_out = op_a & op_b;
            OR:           alu_out = op_a | op_b;
            XOR:          alu_out = op_a ^ op_b;
            SLL:          alu_out = op_a << op_b[3:0];
            ADDI, LW, SW: alu_out = op_a + x_op.imm;
            LI:           alu_out = x_op.imm;
            default:      alu_out = '0;
        endcase
    end

    always_comb
    begin
        r_next.valid  = x_op.valid && !stall_ld;
        r_next.opcode = x_op.opcode;
        r_next.rd     = x_op.rd;
        r_next.value  = alu_out;
        r_next.sdata  = op_b;
        r_next.wr     = writes_rd(x_op.opcode);
    end

    ////////////////////////////////////////
    // Result-stage register
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            r_op.valid <= 1'b0;
            wb_last.en <= 1'b0;
            wb_prev.en <= 1'b0;
        end
        else if (!hold)
        begin
            r_op    <= r_next;
            wb_last <= '{en: w_en, idx: w_idx, data: w_data};
            wb_prev <= wb_last;
        end
    end

    // One bubble per load-use hit and the stall clears after it
    a_stall_bubble : assert property (@(posedge clk) disable iff (rst)
        stall_ld && !hold |=> !r_op.valid && !stall_ld);

endmodule

// File: cpu_decode.sv
`timescale 1ns/1ps

module cpu_decode
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     instr_valid,
    input  instr_u   instr,
    output logic     instr_ready,
    input  logic     hold,
    input  logic     stall_ld,
    input  logic     w_en,
    input  reg_idx_t w_idx,
    input  word_t    w_data,
    output exe_op_t  x_op
);

    logic     frozen;
    logic     f_valid;
    instr_u   f_instr;
    opcode_t  f_op;
    reg_idx_t src_a;
    reg_idx_t src_b;
    word_t    rd_a;
    word_t    rd_b;
    word_t    imm_ext;
    exe_op_t  x_next;

    assign frozen      = hold | stall_ld;
    assign instr_ready = !frozen;

    ////////////////////////////////////////
    // Fetch-side register
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
            f_valid <= 1'b0;
        else if (!frozen)
            f_valid <= instr_valid;
    end

    always_ff @(posedge clk)
    begin
        if (!frozen && instr_valid)
            f_instr <= instr;
    end

    ////////////////////////////////////////
    // Decode and register read
    ////////////////////////////////////////

    // Opcode sits in the same bits for both formats
    assign f_op = f_instr.r.opcode;

    always_comb
    begin
        src_a   = '0;
        src_b   = '0;
        imm_ext = '0;
        case (f_op)
            ADD, SUB, AND, OR, XOR, SLL:
            begin
                src_a = f_instr.r.rs;
                src_b = f_instr.r.rt;
            end
            ADDI, LW:
            begin
                src_a   = f_instr.i.rs;
                imm_ext = {{($bits(word_t) - IMM_W){f_instr.i.imm[IMM_W-1]}}, f_instr.i.imm};
            end
            SW:
            begin
                src_a   = f_instr.i.rs;
                src_b   = f_instr.i.rd;
                imm_ext = {{($bits(word_t) - IMM_W){f_instr.i.imm[IMM_W-1]}}, f_instr.i.imm};
            end
            LI:
                imm_ext = {{($bits(word_t) - IMM_W){1'b0}}, f_instr.i.imm};
            default:
                imm_ext = '0;
        endcase
    end

    cpu_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .ra_idx  (src_a),
        .rb_idx  (src_b),
        .ra_data (rd_a),
        .rb_data (rd_b),
        .w_en    (w_en),
        .w_idx   (w_idx),
        .w_data  (w_data)
    );

    always_comb
    begin
        x_next.valid  = f_valid;
        x_next.opcode = f_op;
        x_next.rd     = f_instr.r.rd;
        x_next.rs     = src_a;
        x_next.rt     = src_b;
        x_next.a      = rd_a;
        x_next.b      = rd_b;
        x_next.imm    = imm_ext;
    end

    // Execute-stage register
    always_ff @(posedge clk)
    begin
        if (rst)
            x_op.valid <= 1'b0;
        else if (!frozen)
            x_op <= x_next;
    end

    // Held or interlocked op stays put for execute
    a_xop_frozen : assert property (@(posedge clk) disable iff (rst)
        (hold || stall_ld) && x_op.valid |=> $stable(x_op));

endmodule

// File: cpu_regfile.sv
`timescale 1ns/1ps

module cpu_regfile
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t ra_idx,
    input  reg_idx_t rb_idx,
    output word_t    ra_data,
    output word_t    rb_data,
    input  logic     w_en,
    input  reg_idx_t w_idx,
    input  word_t    w_data
);

    word_t regs [NUM_REGS];

    // Read ports return the old value during a write
    assign ra_data = regs[ra_idx];
    assign rb_data = regs[rb_idx];

    // r0 is cleared by reset and never written
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (w_en && (w_idx != '0))
        begin
            regs[w_idx] <= w_data;
        end
    end

    // Write index from the result stage must be known
    a_widx_known : assert property (@(posedge clk) disable iff (rst)
        w_en |-> !$isunknown(w_idx));

endmodule

// File: cpu_pipe_pkg.sv
package cpu_pipe_pkg;

    import cpu_isa_pkg::*;

    ////////////////////////////////////////
    // Pipeline sizes
    ////////////////////////////////////////

    localparam int NUM_REGS   = 8;
    localparam int DMEM_WORDS = 16;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    typedef logic [15:0] word_t;

    ////////////////////////////////////////
    // Stage records
    ////////////////////////////////////////

    // Decode to execute
    typedef struct packed {
        logic     valid;
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rs;      // zero when operand a is unused
        reg_idx_t rt;      // zero when operand b is unused
        word_t    a;
        word_t    b;       // rt value, or store data for SW
        word_t    imm;     // already extended
    } exe_op_t;

    // Execute to result
    typedef struct packed {
        logic     valid;
        opcode_t  opcode;
        reg_idx_t rd;
        word_t    value;   // ALU result or memory address
        word_t    sdata;
        logic     wr;
    } res_op_t;

    // Retire record
    // value is the result, the loaded word or the stored word
    // addr is the computed address for LW and SW, zero otherwise
    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rd;
        word_t    value;
        word_t    addr;
    } retire_t;

endpackage

// File: cpu_isa_pkg.sv
package cpu_isa_pkg;

    ////////////////////////////////////////
    // Instruction set
    ////////////////////////////////////////

    localparam int IMM_W = 6;

    typedef enum logic [3:0] {
        NOP  = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        AND  = 4'd3,
        OR   = 4'd4,
        XOR  = 4'd5,
        SLL  = 4'd6,   // shift by rt[3:0]
        ADDI = 4'd7,
        LI   = 4'd8,   // zero-extended immediate
        LW   = 4'd9,
        SW   = 4'd10
    } opcode_t;

    typedef logic [2:0] reg_idx_t;

    // Register format
    typedef struct packed {
        opcode_t    opcode;
        reg_idx_t   rd;
        reg_idx_t   rs;
        reg_idx_t   rt;
        logic [2:0] unused;
    } instr_r_t;

    // Immediate format where SW stores rd at rs + imm
    typedef struct packed {
        opcode_t          opcode;
        reg_idx_t         rd;
        reg_idx_t         rs;
        logic [IMM_W-1:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    // Ops that write their rd
    function automatic logic writes_rd(input opcode_t op);
        logic wr;
        case (op)
            ADD, SUB, AND, OR, XOR, SLL, ADDI, LI, LW: wr = 1'b1;
            default:                                  wr = 1'b0;
        endcase
        return wr;
    endfunction

endpackage
